//--- common/lsu_fwd_pkg.sv
`default_nettype none

package lsu_fwd_pkg;

   //******************************
   // widths
   //******************************
   localparam int addr_w     = 32;
   localparam int data_w     = 32;
   localparam int nbytes     = data_w/8;            // byte lanes per word
   localparam int byte_off_w = $clog2(nbytes);      // low address bits inside a word

   // address with the byte offset stripped off
   typedef logic [addr_w-byte_off_w-1:0] word_addr_t;

   // one enable per byte lane
   typedef logic [nbytes-1:0] byteen_t;

   //******************************
   // write buffer sizing
   //******************************
   localparam int wbuf_depth = 4;

   typedef logic [$clog2(wbuf_depth)-1:0] wbuf_idx_t;
   typedef logic [$clog2(wbuf_depth):0]   wbuf_cnt_t;   // 0 .. wbuf_depth entries

   // stores sitting in dc3, dc4 and dc5 at most three
   typedef logic [1:0] st_cnt_t;

   //******************************
   // access size
   //******************************
   typedef enum logic [1:0] {
      sz_byte = 2'd0,
      sz_half = 2'd1,
      sz_word = 2'd2
   } access_size_t;

   // byte enables for a naturally aligned access
   // byte and half are placed at the byte offset, a word covers all lanes
   function automatic byteen_t size_byteen(input access_size_t          size,
                                           input logic [byte_off_w-1:0] offset);
      byteen_t base;
      case (size)
         sz_byte: base = byteen_t'(1);
         sz_half: base = byteen_t'(3);
         default: base = '1;
      endcase
      if (size == sz_word) begin
         return '1;
      end
      return base << offset;
   endfunction

endpackage

`default_nettype wire

//--- verilog/store_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module store_pipe
   import lsu_fwd_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,

   input  logic                req_valid,
   input  logic                req_load,
   input  access_size_t        req_size,
   input  logic [addr_w-1:0]   req_addr,
   input  logic [data_w-1:0]   req_data,

   // store view of each pipe stage, used for forwarding
   output logic                dc3_st_valid,
   output word_addr_t          dc3_word,
   output byteen_t             dc3_byteen,
   output logic [data_w-1:0]   dc3_data,
   output logic                dc4_st_valid,
   output word_addr_t          dc4_word,
   output byteen_t             dc4_byteen,
   output logic [data_w-1:0]   dc4_data,
   output logic                dc5_st_valid,
   output word_addr_t          dc5_word,
   output byteen_t             dc5_byteen,
   output logic [data_w-1:0]   dc5_data,

   // dc5 hand-off into the write buffer
   output logic                st_push,
   output word_addr_t          st_word,
   output byteen_t             st_byteen,
   output logic [data_w-1:0]   st_data,
   output st_cnt_t             stores_in_flight
);

   logic                st_dc2;
   word_addr_t          word_dc2;
   byteen_t             byteen_dc2;
   logic [data_w-1:0]   data_dc2;

   //******************************
   // dc2 decode
   //******************************
   assign st_dc2     = req_valid & ~req_load;
   assign word_dc2   = req_addr[addr_w-1:byte_off_w];
   assign byteen_dc2 = size_byteen(req_size, req_addr[byte_off_w-1:0]);

   // move store bytes into their lanes once, so later stages need no offset
   assign data_dc2   = req_data << {req_addr[byte_off_w-1:0], 3'b000};

   //******************************
   // dc3 .. dc5 stages
   //******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dc3_st_valid <= 1'b0;
         dc4_st_valid <= 1'b0;
         dc5_st_valid <= 1'b0;
      end else begin
         dc3_st_valid <= st_dc2;         // loads never set the store bit
         dc4_st_valid <= dc3_st_valid;
         dc5_st_valid <= dc4_st_valid;
      end
   end

   // payload only moves when a store enters or is already in flight
   always_ff @(posedge clk) begin
      if (st_dc2) begin
         dc3_word   <= word_dc2;
         dc3_byteen <= byteen_dc2;
         dc3_data   <= data_dc2;
      end
      if (dc3_st_valid) begin
         dc4_word   <= dc3_word;
         dc4_byteen <= dc3_byteen;
         dc4_data   <= dc3_data;
      end
      if (dc4_st_valid) begin
         dc5_word   <= dc4_word;
         dc5_byteen <= dc4_byteen;
         dc5_data   <= dc4_data;
      end
   end

   // dc5 store enters the buffer at the next edge
   assign st_push   = dc5_st_valid;
   assign st_word   = dc5_word;
   assign st_byteen = dc5_byteen;
   assign st_data   = dc5_data;

   // reserved buffer slots for stores not yet pushed
   assign stores_in_flight = {1'b0, dc3_st_valid} +
                             {1'b0, dc4_st_valid} +
                             {1'b0, dc5_st_valid};

endmodule

`default_nettype wire

//--- write_buffer/write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module write_buffer
   import lsu_fwd_pkg::*;
(
   input  logic                                  clk,
   input  logic                                  rst_n,

   // store from dc5
   input  logic                                  st_push,
   input  word_addr_t                            st_word,
   input  byteen_t                               st_byteen,
   input  logic [data_w-1:0]                     st_data,
   input  st_cnt_t                               stores_in_flight,
   input  logic                                  wb_coalescing_disable,

   // entry view for load forwarding
   output logic [wbuf_depth-1:0]                 wb_vld,
   output word_addr_t [wbuf_depth-1:0]           wb_word,
   output byteen_t [wbuf_depth-1:0]              wb_byteen,
   output logic [wbuf_depth-1:0][data_w-1:0]     wb_data,
   output wbuf_idx_t                             wb_youngest,

   output logic                                  wbuf_full,
   output logic                                  wbuf_empty,

   // bus write port
   output logic                                  bus_wr_valid,
   input  logic                                  bus_wr_ready,
   output logic [addr_w-1:0]                     bus_wr_addr,
   output byteen_t                               bus_wr_byteen,
   output logic [data_w-1:0]                     bus_wr_data
);

   wbuf_idx_t           wb_head;       // oldest entry, drives the bus
   wbuf_idx_t           wb_tail;       // next free slot
   wbuf_cnt_t           wb_count;
   logic                wb_drain;
   logic                wb_merge;
   logic                wb_alloc;
   logic [data_w-1:0]   merged_data;

   assign wb_youngest = wb_tail - 1'b1;

   //******************************
   // push decision
   //******************************
   // merge only into an entry that is not about to drain
   assign wb_merge = st_push & ~wb_coalescing_disable &
                     (wb_count >= wbuf_cnt_t'(2)) &
                     (wb_word[wb_youngest] == st_word);
   assign wb_alloc = st_push & ~wb_merge;

   // newer bytes win, untouched lanes keep the old data
   always_comb begin
      merged_data = wb_data[wb_youngest];
      for (int b = 0; b < nbytes; b++) begin
         if (st_byteen[b]) begin
            merged_data[8*b +: 8] = st_data[8*b +: 8];
         end
      end
   end

   //******************************
   // pointers and valid bits
   //******************************
   assign wb_drain = bus_wr_valid & bus_wr_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_head  <= '0;
         wb_tail  <= '0;
         wb_count <= '0;
         wb_vld   <= '0;
      end else begin
         if (wb_drain) begin
            wb_vld[wb_head] <= 1'b0;
            wb_head         <= wb_head + 1'b1;
         end
         if (wb_alloc) begin
            wb_vld[wb_tail] <= 1'b1;
            wb_tail         <= wb_tail + 1'b1;
         end
         wb_count <= wb_count + wbuf_cnt_t'(wb_alloc) - wbuf_cnt_t'(wb_drain);
      end
   end

   // entry payload
   always_ff @(posedge clk) begin
      if (wb_alloc) begin
         wb_word[wb_tail]   <= st_word;
         wb_byteen[wb_tail] <= st_byteen;
         wb_data[wb_tail]   <= st_data;
      end else if (wb_merge) begin
         wb_byteen[wb_youngest] <= wb_byteen[wb_youngest] | st_byteen;
         wb_data[wb_youngest]   <= merged_data;
      end
   end

   //******************************
   // status and bus drain
   //******************************
   // in-flight stores already own a slot, so dc2 never overruns the buffer
   assign wbuf_full  = (wb_count + wbuf_cnt_t'(stores_in_flight)) >= wbuf_cnt_t'(wbuf_depth);
   assign wbuf_empty = (wb_count == '0);

   assign bus_wr_valid  = wb_vld[wb_head];   // held until ready
   assign bus_wr_addr   = {wb_word[wb_head], {byte_off_w{1'b0}}};
   assign bus_wr_byteen = wb_byteen[wb_head];
   assign bus_wr_data   = wb_data[wb_head];

endmodule

`default_nettype wire

//--- verilog/ld_forward.sv
`timescale 1ns/1ps
`default_nettype none

module ld_forward
   import lsu_fwd_pkg::*;
(
   input  logic                                  clk,
   input  logic                                  rst_n,

   input  logic                                  req_valid,
   input  logic                                  req_load,
   input  access_size_t                          req_size,
   input  logic [addr_w-1:0]                     req_addr,
   input  logic [data_w-1:0]                     bus_rdata,

   // older stores still in the pipe
   input  logic                                  dc3_st_valid,
   input  word_addr_t                            dc3_word,
   input  byteen_t                               dc3_byteen,
   input  logic [data_w-1:0]                     dc3_data,
   input  logic                                  dc4_st_valid,
   input  word_addr_t                            dc4_word,
   input  byteen_t                               dc4_byteen,
   input  logic [data_w-1:0]                     dc4_data,
   input  logic                                  dc5_st_valid,
   input  word_addr_t                            dc5_word,
   input  byteen_t                               dc5_byteen,
   input  logic [data_w-1:0]                     dc5_data,

   // write buffer contents
   input  logic [wbuf_depth-1:0]                 wb_vld,
   input  word_addr_t [wbuf_depth-1:0]           wb_word,
   input  byteen_t [wbuf_depth-1:0]              wb_byteen,
   input  logic [wbuf_depth-1:0][data_w-1:0]     wb_data,
   input  wbuf_idx_t                             wb_youngest,

   output logic                                  ld_valid,
   output logic [data_w-1:0]                     ld_data,
   output logic                                  ld_full_hit
);

   logic                ld_req;
   word_addr_t          ld_word;
   byteen_t             ld_byteen;
   byteen_t             dc3_hit, dc4_hit, dc5_hit;
   byteen_t             byte_hit;
   wbuf_idx_t           wb_idx;
   logic [data_w-1:0]   fwd_word;
   logic [data_w-1:0]   shifted;
   logic [data_w-1:0]   extended;
   logic                full_hit;

   assign ld_req    = req_valid & req_load;
   assign ld_word   = req_addr[addr_w-1:byte_off_w];
   assign ld_byteen = size_byteen(req_size, req_addr[byte_off_w-1:0]);

   // per-lane hits against the pipe stages
   assign dc3_hit = {nbytes{dc3_st_valid & (dc3_word == ld_word)}} & dc3_byteen;
   assign dc4_hit = {nbytes{dc4_st_valid & (dc4_word == ld_word)}} & dc4_byteen;
   assign dc5_hit = {nbytes{dc5_st_valid & (dc5_word == ld_word)}} & dc5_byteen;

   //******************************
   // byte select
   //******************************
   // walk from the oldest source to the youngest, later hits overwrite
   always_comb begin
      fwd_word = bus_rdata;                  // default when nothing covers the lane
      byte_hit = '0;
      wb_idx   = wb_youngest;
      for (int b = 0; b < nbytes; b++) begin
         for (int k = wbuf_depth-1; k >= 0; k--) begin
            wb_idx = wb_youngest - wbuf_idx_t'(k);
            if (wb_vld[wb_idx] && (wb_word[wb_idx] == ld_word) && wb_byteen[wb_idx][b]) begin
               fwd_word[8*b +: 8] = wb_data[wb_idx][8*b +: 8];
               byte_hit[b]        = 1'b1;
            end
         end
         if (dc5_hit[b]) begin
            fwd_word[8*b +: 8] = dc5_data[8*b +: 8];
            byte_hit[b]        = 1'b1;
         end
         if (dc4_hit[b]) begin
            fwd_word[8*b +: 8] = dc4_data[8*b +: 8];
            byte_hit[b]        = 1'b1;
         end
         if (dc3_hit[b]) begin                // youngest older store
            fwd_word[8*b +: 8] = dc3_data[8*b +: 8];
            byte_hit[b]        = 1'b1;
         end
      end
   end

   //******************************
   // align and extend
   //******************************
   assign shifted = fwd_word >> {req_addr[byte_off_w-1:0], 3'b000};

   always_comb begin
      case (req_size)
         sz_byte: extended = {{(data_w-8){1'b0}}, shifted[7:0]};
         sz_half: extended = {{(data_w-16){1'b0}}, shifted[15:0]};
         default: extended = shifted;
      endcase
   end

   assign full_hit = ld_req & ((byte_hit & ld_byteen) == ld_byteen);

   // dc3 result registers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_valid <= 1'b0;
      end else begin
         ld_valid <= ld_req;
      end
   end

   always_ff @(posedge clk) begin
      ld_data     <= extended;
      ld_full_hit <= full_hit;
   end

endmodule

`default_nettype wire

//--- verilog/lsu_bus_intf.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_intf
   import lsu_fwd_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,

   // dc2 request
   input  logic                req_valid,
   input  logic                req_load,
   input  access_size_t        req_size,
   input  logic [addr_w-1:0]   req_addr,
   input  logic [data_w-1:0]   req_data,
   input  logic [data_w-1:0]   bus_rdata,        // sampled with the request

   input  logic                wb_coalescing_disable,

   // bus write port
   output logic                bus_wr_valid,
   input  logic                bus_wr_ready,
   output logic [addr_w-1:0]   bus_wr_addr,
   output byteen_t             bus_wr_byteen,
   output logic [data_w-1:0]   bus_wr_data,

   // dc3 load result
   output logic                ld_valid,
   output logic [data_w-1:0]   ld_data,
   output logic                ld_full_hit,

   output logic                wbuf_full,
   output logic                wbuf_empty
);

   // pipe stage stores
   logic                dc3_st_valid, dc4_st_valid, dc5_st_valid;
   word_addr_t          dc3_word, dc4_word, dc5_word;
   byteen_t             dc3_byteen, dc4_byteen, dc5_byteen;
   logic [data_w-1:0]   dc3_data, dc4_data, dc5_data;

   // dc5 to buffer
   logic                st_push;
   word_addr_t          st_word;
   byteen_t             st_byteen;
   logic [data_w-1:0]   st_data;
   st_cnt_t             stores_in_flight;

   // buffer entries
   logic [wbuf_depth-1:0]               wb_vld;
   word_addr_t [wbuf_depth-1:0]         wb_word;
   byteen_t [wbuf_depth-1:0]            wb_byteen;
   logic [wbuf_depth-1:0][data_w-1:0]   wb_data;
   wbuf_idx_t                           wb_youngest;

   store_pipe   u_store_pipe   (.*);
   write_buffer u_write_buffer (.*);
   ld_forward   u_ld_forward   (.*);

endmodule

`default_nettype wire

//--- dv/lsu_ref_model.svh
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

   //******************************
   // shadow memory
   //******************************
   logic [7:0]   shadow  [win_words*nbytes];   // every store applied at issue
   logic         written [win_words*nbytes];   // byte stored since the last clear
   int           stores_issued = 0;

   // initial word contents, every address bit takes part
   function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] addr);
      return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6b1d_c2e5;
   endfunction

   function automatic int byte_off(input logic [addr_w-1:0] addr);
      return addr - win_base;
   endfunction

   function automatic int word_idx(input logic [addr_w-1:0] addr);
      return byte_off(addr) / nbytes;
   endfunction

   function automatic int size_bytes(input access_size_t size);
      case (size)
         sz_byte: return 1;
         sz_half: return 2;
         default: return 4;
      endcase
   endfunction

   function automatic void clear_written();
      for (int i = 0; i < win_words*nbytes; i++) begin
         written[i] = 1'b0;
      end
   endfunction

   function automatic void init_shadow();
      logic [data_w-1:0] w;
      for (int i = 0; i < win_words*nbytes; i++) begin
         w         = fill_word(win_base + i - i % nbytes);
         shadow[i] = w[8*(i % nbytes) +: 8];
      end
      clear_written();
   endfunction

   // store data is little endian from the access address up
   function automatic void ref_store(input access_size_t size, input logic [addr_w-1:0] addr,
                                     input logic [data_w-1:0] data);
      for (int i = 0; i < size_bytes(size); i++) begin
         shadow[byte_off(addr) + i]  = data[8*i +: 8];
         written[byte_off(addr) + i] = 1'b1;
      end
      stores_issued++;
   endfunction

   function automatic logic [data_w-1:0] ref_load(input access_size_t size,
                                                  input logic [addr_w-1:0] addr);
      logic [data_w-1:0] result;
      result = '0;                                   // upper bytes stay zero
      for (int i = 0; i < size_bytes(size); i++) begin
         result[8*i +: 8] = shadow[byte_off(addr) + i];
      end
      return result;
   endfunction

   // full hit when every byte read was stored since the last clear
   function automatic logic ref_full_hit(input access_size_t size, input logic [addr_w-1:0] addr);
      logic hit;
      hit = 1'b1;
      for (int i = 0; i < size_bytes(size); i++) begin
         hit = hit & written[byte_off(addr) + i];
      end
      return hit;
   endfunction

   function automatic logic [data_w-1:0] shadow_word(input int idx);
      return {shadow[4*idx+3], shadow[4*idx+2], shadow[4*idx+1], shadow[4*idx]};
   endfunction

`endif

//--- dv/lsu_bus_intf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_intf_tb
   import lsu_fwd_pkg::*;
();

   localparam int                win_words = 8;          // small window so accesses collide
   localparam logic [addr_w-1:0] win_base  = 32'h0000_2000;
   localparam int                n_rand    = 400;
   localparam int                n_hit     = 80;
   localparam int                n_nocoal  = 120;
   localparam int                n_coal    = 8;          // more stores than wbuf_depth
   localparam int                total_ops = n_rand + n_hit + n_nocoal + n_coal;

   logic                clk, rst_n;
   logic                req_valid, req_load;
   access_size_t        req_size;
   logic [addr_w-1:0]   req_addr, bus_wr_addr;
   logic [data_w-1:0]   req_data, bus_rdata, bus_wr_data, ld_data;
   logic                wb_coalescing_disable, bus_wr_valid, bus_wr_ready;
   byteen_t             bus_wr_byteen;
   logic                ld_valid, ld_full_hit, wbuf_full, wbuf_empty;

   logic [data_w-1:0]   bus_mem [win_words];
   logic [data_w+1:0]   exp_q [$];                  // {check hit, full hit, data}
   int                  wr_count  = 0;
   integer              seed      = 32'heee81678;
   string               test_name = "reset";

   `include "lsu_ref_model.svh"

   lsu_bus_intf DUT (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (total_ops*40) @(posedge clk);
      $display("ERROR: watchdog timeout, the run did not finish in time");
      $display("Test failures found");
      $fatal(1, "watchdog expired");
   end

   //******************************
   // bus memory and compare
   //******************************
   always @(posedge clk) begin
      if (rst_n && bus_wr_valid && bus_wr_ready) begin
         for (int b = 0; b < nbytes; b++) begin
            if (bus_wr_byteen[b]) begin
               bus_mem[word_idx(bus_wr_addr)][8*b +: 8] <= bus_wr_data[8*b +: 8];
            end
         end
         wr_count <= wr_count + 1;
      end
   end

   always @(posedge clk) begin : compare_loads
      logic [data_w+1:0] expected_entry;
      if (rst_n && ld_valid) begin
         if (exp_q.size() == 0) begin
            $display("ERROR: load result arrived with no load outstanding");
            $display("Test failures found");
            $fatal(1, "unexpected load result");
         end else begin
            expected_entry = exp_q.pop_front();
            check_value(test_name, expected_entry[data_w-1:0], ld_data);
            if (expected_entry[data_w+1]) begin
               check_value("ld_full_hit", expected_entry[data_w], ld_full_hit);
            end
         end
      end
   end

   task automatic check_value(input string name, input logic [data_w-1:0] expected,
                              input logic [data_w-1:0] actual);
      if (actual !== expected) begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         $display("Test failures found");
         $fatal(1, "stopping at the first error");
      end
   endtask

   // next drive point, 1 ns after the edge
   task automatic next_slot();
      @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   function automatic logic [addr_w-1:0] align_addr(input access_size_t size,
                                                    input logic [addr_w-1:0] addr);
      return addr - (addr % size_bytes(size));
   endfunction

   task automatic drive_op(input logic load, input access_size_t size,
                           input logic [addr_w-1:0] addr, input logic chk_hit);
      logic [data_w-1:0] data;
      data      = $random(seed);
      req_valid = 1'b1;
      req_load  = load;
      req_size  = size;
      req_addr  = addr;
      req_data  = data;
      bus_rdata = bus_mem[word_idx(addr)];          // read data travels with the request
      if (load) begin
         exp_q.push_back({chk_hit, ref_full_hit(size, addr), ref_load(size, addr)});
      end else begin
         ref_store(size, addr, data);
      end
   endtask

   task automatic random_op(input logic chk_hit);
      access_size_t        size;
      logic [addr_w-1:0]   addr;
      size = access_size_t'({$random(seed)} % 3);
      addr = align_addr(size, win_base + {$random(seed)} % (win_words*nbytes));
      drive_op(($random(seed) % 2 == 0) || wbuf_full, size, addr, chk_hit);   // no store when full
   endtask

   // let the pipe empty, drain the buffer, then compare memories
   task automatic drain_and_check();
      bus_wr_ready = 1'b1;
      repeat (4) next_slot();
      while (!wbuf_empty) begin
         next_slot();
      end
      check_value("pending_loads", 0, exp_q.size());
      for (int i = 0; i < win_words; i++) begin
         check_value("final_memory", shadow_word(i), bus_mem[i]);
      end
   endtask

   //******************************
   // test sequence
   //******************************
   initial begin
      access_size_t   size;
      int             st0;
      int             wr0;
      rst_n                 = 1'b0;
      req_valid             = 1'b0;
      req_load              = 1'b0;
      req_size              = sz_word;
      req_addr              = '0;
      req_data              = '0;
      bus_rdata             = '0;
      wb_coalescing_disable = 1'b0;
      bus_wr_ready          = 1'b0;
      for (int i = 0; i < win_words; i++) begin
         bus_mem[i] = fill_word(win_base + nbytes*i);
      end
      init_shadow();
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_value("reset_state", 4'b0010, {ld_valid, bus_wr_valid, wbuf_empty, wbuf_full});

      test_name = "load_data";
      repeat (n_rand) begin
         next_slot();
         bus_wr_ready = ($random(seed) % 4) != 0;
         random_op(1'b0);
      end
      drain_and_check();

      // ready held low, so every stored byte is still in the pipe or buffer
      test_name = "full_hit";
      clear_written();
      repeat (n_hit) begin
         next_slot();
         bus_wr_ready = 1'b0;
         random_op(1'b1);
      end
      drain_and_check();

      test_name             = "coalesce_off";
      wb_coalescing_disable = 1'b1;
      st0                   = stores_issued;
      wr0                   = wr_count;
      repeat (n_nocoal) begin
         next_slot();
         bus_wr_ready = ($random(seed) % 4) != 0;
         random_op(1'b0);
      end
      drain_and_check();
      check_value("coalesce_off", stores_issued - st0, wr_count - wr0);

      test_name             = "coalesce_on";
      wb_coalescing_disable = 1'b0;
      bus_wr_ready          = 1'b0;
      wr0                   = wr_count;
      repeat (n_coal) begin
         next_slot();
         check_value("coalesce_full", 0, wbuf_full);
         size = access_size_t'({$random(seed)} % 3);
         drive_op(1'b0, size,
                  align_addr(size, win_base + 3*nbytes + {$random(seed)} % nbytes), 1'b0);
         repeat (3) next_slot();                     // store reaches the buffer
      end
      next_slot();
      check_value("coalesce_full", 0, wbuf_full);
      drain_and_check();
      // the first entry is the oldest, so only the second one absorbs the rest
      check_value("coalesce_on", 2, wr_count - wr0);

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+dv
common/lsu_fwd_pkg.sv
verilog/store_pipe.sv
write_buffer/write_buffer.sv
verilog/ld_forward.sv
verilog/lsu_bus_intf.sv
dv/lsu_bus_intf_tb.sv

//--- Bender.yml
package:
  name: lsu_bus_intf

sources:
  - files:
      - common/lsu_fwd_pkg.sv
      - verilog/store_pipe.sv
      - write_buffer/write_buffer.sv
      - verilog/ld_forward.sv
      - verilog/lsu_bus_intf.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/lsu_bus_intf_tb.sv
